/* a2_pkg.sv */
/* Shared widths, filter settings and enums for the Apple II bus front end.
   The output enable switches are fixed here and apply to the whole design. */
package a2_pkg;

    // Apple II slot bus widths
    localparam int A2_ADDR_W = 16;
    localparam int A2_DATA_W = 8;

    // Synchronizer depth for the slow slot clocks
    localparam int SYNC_STAGES = 2;

    // Equal synchronized samples needed before a level change is accepted
    localparam int FILTER_LEN = 3;

    // Width of the run counter in the denoiser
    localparam int FILTER_CNT_W = $clog2(FILTER_LEN);

    // Permits driving the data direction output
    localparam bit BUS_DATA_OUT_ENABLE = 1'b1;

    // Permits driving the Apple interrupt line
    localparam bit IRQ_OUT_ENABLE = 1'b1;

    // Capture state within one Phi0 cycle
    typedef enum logic [1:0] {
        // Waiting for Phi1 to fall
        CAP_WAIT_PHI0,
        // Address latched, no data yet
        CAP_WAIT_DATA,
        // Data latched, waiting for Phi1 to rise
        CAP_WAIT_END
    } cap_state_e;

    // Source that drives the Apple data bus
    typedef enum logic [1:0] {
        CARD_NONE,
        // Serial card
        CARD_SSC,
        // Sprite card
        CARD_SSP,
        // Sound card
        CARD_MB
    } card_sel_e;

endpackage

/* edge_denoise.sv */
/* Input is asynchronous. Level and edge strobes follow a stable change by
   4 to 5 clocks; pulses shorter than FILTER_LEN samples are dropped. */
module edge_denoise import a2_pkg::*; (
    input  logic clk_logic_w,
    input  logic rst_n_i,
    input  logic sig_i,
    output logic level_o,
    output logic rise_o,
    output logic fall_o
);

    logic [SYNC_STAGES-1:0]  sync_q;
    logic                    sync_w;
    logic [FILTER_CNT_W-1:0] run_cnt_q;
    logic                    level_q;
    logic                    rise_q;
    logic                    fall_q;

    assign sync_w = sync_q[SYNC_STAGES-1];

    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            // Slot clocks idle high, so start from the high level
            sync_q    <= '1;
            run_cnt_q <= '0;
            level_q   <= 1'b1;
            rise_q    <= 1'b0;
            fall_q    <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], sig_i};
            rise_q <= 1'b0;
            fall_q <= 1'b0;
            if (sync_w == level_q) begin
                // Glitch ended before it was accepted
                run_cnt_q <= '0;
            end else if (run_cnt_q == FILTER_CNT_W'(FILTER_LEN - 1)) begin
                level_q   <= sync_w;
                rise_q    <= sync_w;
                fall_q    <= !sync_w;
                run_cnt_q <= '0;
            end else begin
                run_cnt_q <= run_cnt_q + 1'b1;
            end
        end
    end

    assign level_o = level_q;
    assign rise_o  = rise_q;
    assign fall_o  = fall_q;

    // A new edge needs a fresh run of samples, so strobes never come back to back
    a_edge_gap: assert property (
        @(posedge clk_logic_w) disable iff (!rst_n_i)
        (rise_o || fall_o) |=> !(rise_o || fall_o)
    );

endmodule

/* bus_cycle_capture.sv */
/* One cycle in flight; the report holds until the next strobe. Without a Q3
   fall inside Phi0 the data is taken at the Phi1 rise. */
module bus_cycle_capture import a2_pkg::*; (
    input  logic                 clk_logic_w,
    input  logic                 rst_n_i,
    input  logic                 phi1_rise_i,
    input  logic                 phi1_fall_i,
    input  logic                 q3_fall_i,
    input  logic [A2_ADDR_W-1:0] addr_i,
    input  logic [A2_DATA_W-1:0] data_i,
    input  logic                 rw_n_i,
    output logic                 cycle_strobe_o,
    output logic [A2_ADDR_W-1:0] cycle_addr_o,
    output logic [A2_DATA_W-1:0] cycle_data_o,
    output logic                 cycle_rw_n_o
);

    cap_state_e           state_q;
    logic [A2_ADDR_W-1:0] addr_q;
    logic [A2_DATA_W-1:0] data_q;
    logic                 rw_n_q;
    logic [A2_DATA_W-1:0] report_data_w;

    // Late data comes straight from the bus when Q3 never fell
    assign report_data_w = (state_q == CAP_WAIT_END) ? data_q : data_i;

    // Pending cycle, kept apart from the held report
    always_ff @(posedge clk_logic_w) begin
        if (phi1_fall_i) begin
            addr_q <= addr_i;
            rw_n_q <= rw_n_i;
        end
        if (state_q == CAP_WAIT_DATA && q3_fall_i) begin
            data_q <= data_i;
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            state_q        <= CAP_WAIT_PHI0;
            cycle_strobe_o <= 1'b0;
            cycle_addr_o   <= '0;
            cycle_data_o   <= '0;
            cycle_rw_n_o   <= 1'b0;
        end else begin
            cycle_strobe_o <= 1'b0;
            if (phi1_fall_i) begin
                // Start of Phi0, also restarts a cycle whose end was lost
                state_q <= CAP_WAIT_DATA;
            end else begin
                case (state_q)
                    CAP_WAIT_DATA: begin
                        if (phi1_rise_i) begin
                            state_q        <= CAP_WAIT_PHI0;
                            cycle_strobe_o <= 1'b1;
                            cycle_addr_o   <= addr_q;
                            cycle_rw_n_o   <= rw_n_q;
                            cycle_data_o   <= report_data_w;
                        end else if (q3_fall_i) begin
                            state_q <= CAP_WAIT_END;
                        end
                    end
                    CAP_WAIT_END: begin
                        if (phi1_rise_i) begin
                            state_q        <= CAP_WAIT_PHI0;
                            cycle_strobe_o <= 1'b1;
                            cycle_addr_o   <= addr_q;
                            cycle_rw_n_o   <= rw_n_q;
                            cycle_data_o   <= report_data_w;
                        end
                    end
                    default: begin
                        state_q <= CAP_WAIT_PHI0;
                    end
                endcase
            end
        end
    end

    // At most one report per Phi0 cycle
    a_strobe_single: assert property (
        @(posedge clk_logic_w) disable iff (!rst_n_i)
        cycle_strobe_o |=> !cycle_strobe_o
    );

endmodule

/* card_response_arbiter.sv */
/* Purely combinational. Serial card wins over sprite card, which wins over
   the sound card; with no read-enable the captured bus byte is driven. */
module card_response_arbiter import a2_pkg::*; (
    input  logic                 ssc_rd_i,
    input  logic [A2_DATA_W-1:0] ssc_data_i,
    input  logic                 ssc_irq_n_i,
    input  logic                 ssp_rd_i,
    input  logic [A2_DATA_W-1:0] ssp_data_i,
    input  logic                 ssp_irq_n_i,
    input  logic                 mb_rd_i,
    input  logic [A2_DATA_W-1:0] mb_data_i,
    input  logic                 mb_irq_n_i,
    input  logic [A2_DATA_W-1:0] bus_data_i,
    output logic [A2_DATA_W-1:0] a2_d_o,
    output logic                 a2_d_dir_o,
    output logic                 a2_irq_n_o
);

    card_sel_e sel_w;

    // Fixed priority pick
    always_comb begin
        if (ssc_rd_i) begin
            sel_w = CARD_SSC;
        end else if (ssp_rd_i) begin
            sel_w = CARD_SSP;
        end else if (mb_rd_i) begin
            sel_w = CARD_MB;
        end else begin
            sel_w = CARD_NONE;
        end
    end

    always_comb begin
        case (sel_w)
            CARD_SSC: a2_d_o = ssc_data_i;
            CARD_SSP: a2_d_o = ssp_data_i;
            CARD_MB:  a2_d_o = mb_data_i;
            default:  a2_d_o = bus_data_i;
        endcase
    end

    // Drive the bus only while some card answers a read
    assign a2_d_dir_o = (sel_w != CARD_NONE) && BUS_DATA_OUT_ENABLE;

    // Interrupt lines are wired-AND, active low
    assign a2_irq_n_o = IRQ_OUT_ENABLE ? (ssc_irq_n_i && ssp_irq_n_i && mb_irq_n_i) : 1'b1;

endmodule

/* a2_bus_frontend.sv */
/* Phi1 and Q3 may be asynchronous to clk_logic_w; a cycle report follows the
   Phi1 rise at the pin by 5 to 6 clocks. Card inputs reach the bus outputs directly. */
module a2_bus_frontend import a2_pkg::*; (
    input  logic                 clk_logic_w,
    input  logic                 rst_n_i,
    input  logic                 a2_phi1_i,
    input  logic                 a2_q3_i,
    input  logic [A2_ADDR_W-1:0] a2_a_i,
    input  logic [A2_DATA_W-1:0] a2_d_i,
    input  logic                 a2_rw_n_i,
    input  logic                 ssc_rd_i,
    input  logic [A2_DATA_W-1:0] ssc_data_i,
    input  logic                 ssc_irq_n_i,
    input  logic                 ssp_rd_i,
    input  logic [A2_DATA_W-1:0] ssp_data_i,
    input  logic                 ssp_irq_n_i,
    input  logic                 mb_rd_i,
    input  logic [A2_DATA_W-1:0] mb_data_i,
    input  logic                 mb_irq_n_i,
    output logic                 phi0_o,
    output logic                 cycle_strobe_o,
    output logic [A2_ADDR_W-1:0] cycle_addr_o,
    output logic [A2_DATA_W-1:0] cycle_data_o,
    output logic                 cycle_rw_n_o,
    output logic [A2_DATA_W-1:0] a2_d_o,
    output logic                 a2_d_dir_o,
    output logic                 a2_irq_n_o
);

    logic phi1_level_w;
    logic phi1_rise_w;
    logic phi1_fall_w;
    logic q3_fall_w;

    // Phi1 falls at the start of Phi0 and rises at its end
    edge_denoise phi1_denoise (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .sig_i       (a2_phi1_i),
        .level_o     (phi1_level_w),
        .rise_o      (phi1_rise_w),
        .fall_o      (phi1_fall_w)
    );

    // Only the Q3 fall matters, it marks valid write data
    edge_denoise q3_denoise (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .sig_i       (a2_q3_i),
        .level_o     (),
        .rise_o      (),
        .fall_o      (q3_fall_w)
    );

    assign phi0_o = !phi1_level_w;

    bus_cycle_capture capture (
        .clk_logic_w    (clk_logic_w),
        .rst_n_i        (rst_n_i),
        .phi1_rise_i    (phi1_rise_w),
        .phi1_fall_i    (phi1_fall_w),
        .q3_fall_i      (q3_fall_w),
        .addr_i         (a2_a_i),
        .data_i         (a2_d_i),
        .rw_n_i         (a2_rw_n_i),
        .cycle_strobe_o (cycle_strobe_o),
        .cycle_addr_o   (cycle_addr_o),
        .cycle_data_o   (cycle_data_o),
        .cycle_rw_n_o   (cycle_rw_n_o)
    );

    // Last captured byte is the fallback drive value
    card_response_arbiter arbiter (
        .ssc_rd_i    (ssc_rd_i),
        .ssc_data_i  (ssc_data_i),
        .ssc_irq_n_i (ssc_irq_n_i),
        .ssp_rd_i    (ssp_rd_i),
        .ssp_data_i  (ssp_data_i),
        .ssp_irq_n_i (ssp_irq_n_i),
        .mb_rd_i     (mb_rd_i),
        .mb_data_i   (mb_data_i),
        .mb_irq_n_i  (mb_irq_n_i),
        .bus_data_i  (cycle_data_o),
        .a2_d_o      (a2_d_o),
        .a2_d_dir_o  (a2_d_dir_o),
        .a2_irq_n_o  (a2_irq_n_o)
    );

endmodule

/* tb_a2_bus_frontend.sv */
/* Directed tests for the bus front end. Slot clocks are driven as slow levels
   on the falling edge of clk_logic_w; all outputs are sampled on that edge. */
module tb_a2_bus_frontend import a2_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 40;
    localparam int SEED        = 32'hb82f486e;
    // Six tests of up to forty bus cycles of forty clocks, with a factor two margin
    localparam int WATCHDOG_NS = 6 * 40 * 40 * CLK_PERIOD * 2;

    logic                 clk_logic_w;
    logic                 rst_n_i;
    logic                 a2_phi1_i;
    logic                 a2_q3_i;
    logic [A2_ADDR_W-1:0] a2_a_i;
    logic [A2_DATA_W-1:0] a2_d_i;
    logic                 a2_rw_n_i;
    logic                 ssc_rd_i;
    logic [A2_DATA_W-1:0] ssc_data_i;
    logic                 ssc_irq_n_i;
    logic                 ssp_rd_i;
    logic [A2_DATA_W-1:0] ssp_data_i;
    logic                 ssp_irq_n_i;
    logic                 mb_rd_i;
    logic [A2_DATA_W-1:0] mb_data_i;
    logic                 mb_irq_n_i;
    logic                 phi0_o;
    logic                 cycle_strobe_o;
    logic [A2_ADDR_W-1:0] cycle_addr_o;
    logic [A2_DATA_W-1:0] cycle_data_o;
    logic                 cycle_rw_n_o;
    logic [A2_DATA_W-1:0] a2_d_o;
    logic                 a2_d_dir_o;
    logic                 a2_irq_n_o;

    int                   errors;
    int                   tests_run;
    int                   tests_failed;
    int                   strobe_seen;
    logic [A2_ADDR_W-1:0] got_addr;
    logic [A2_DATA_W-1:0] got_data;
    logic                 got_rw_n;
    // Data byte of the last reported cycle, the arbiter fallback
    logic [A2_DATA_W-1:0] last_data;

    a2_bus_frontend DUT (.*);

    always #(CLK_PERIOD / 2) clk_logic_w = ~clk_logic_w;

    // Advance n falling edges and record every cycle report seen
    task automatic tick(input int n);
        repeat (n) begin
            @(negedge clk_logic_w);
            if (cycle_strobe_o) begin
                strobe_seen++;
                got_addr = cycle_addr_o;
                got_data = cycle_data_o;
                got_rw_n = cycle_rw_n_o;
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("MISMATCH %s expected %h got %h", name, exp, got);
    endtask

    task automatic end_test(input string name, input int err_start);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("test %s done, %0d errors", name, errors - err_start);
    endtask

    // One Phi0 cycle; without Q3 the real data only appears late in Phi0
    task automatic run_bus_cycle(input logic [A2_ADDR_W-1:0] addr,
                                 input logic [A2_DATA_W-1:0] data,
                                 input logic rw_n, input bit use_q3,
                                 input bit q3_glitch);
        int waited;
        strobe_seen = 0;
        waited = 0;
        a2_phi1_i = 1'b0;
        a2_a_i    = addr;
        a2_rw_n_i = rw_n;
        a2_d_i    = (use_q3 && !q3_glitch) ? data : ~data;
        if (q3_glitch) begin
            // Short Q3 pulse once Phi0 is accepted, while a wrong byte is on the bus
            tick(6);
            a2_q3_i = 1'b0;
            tick(1);
            a2_q3_i = 1'b1;
            tick(3);
        end else begin
            tick(10);
        end
        if (use_q3) begin
            a2_q3_i = 1'b0;
        end
        a2_d_i = data;
        tick(10);
        if (phi0_o !== 1'b1) report_mismatch("phi0_o", 1, phi0_o);
        a2_phi1_i = 1'b1;
        a2_q3_i   = 1'b1;
        while (strobe_seen == 0 && waited < 20) begin
            tick(1);
            waited++;
        end
        if (strobe_seen == 0) begin
            errors++;
            $display("no cycle strobe within 20 cycles of the Phi1 rise");
        end else begin
            tick(2);
            if (strobe_seen != 1) report_mismatch("strobe_count", 1, strobe_seen);
            if (got_addr !== addr) report_mismatch("cycle_addr_o", addr, got_addr);
            if (got_data !== data) report_mismatch("cycle_data_o", data, got_data);
            if (got_rw_n !== rw_n) report_mismatch("cycle_rw_n_o", rw_n, got_rw_n);
            if (phi0_o !== 1'b0) report_mismatch("phi0_o", 0, phi0_o);
        end
        last_data = data;
    endtask

    task automatic test_after_reset();
        int err_start;
        err_start = errors;
        strobe_seen = 0;
        tick(20);
        if (strobe_seen != 0) report_mismatch("strobe_count", 0, strobe_seen);
        if (phi0_o !== 1'b0) report_mismatch("phi0_o", 0, phi0_o);
        if (a2_d_dir_o !== 1'b0) report_mismatch("a2_d_dir_o", 0, a2_d_dir_o);
        if (a2_irq_n_o !== 1'b1) report_mismatch("a2_irq_n_o", 1, a2_irq_n_o);
        end_test("after_reset", err_start);
    endtask

    task automatic test_cycle_capture();
        int err_start;
        err_start = errors;
        for (int i = 0; i < 30; i++) begin
            run_bus_cycle(A2_ADDR_W'($urandom), A2_DATA_W'($urandom), 1'($urandom),
                          1'b1, 1'b0);
        end
        end_test("cycle_capture", err_start);
    endtask

    task automatic test_glitch_reject();
        int err_start;
        err_start = errors;
        strobe_seen = 0;
        // One clock of Phi1 low must not start a cycle
        a2_phi1_i = 1'b0;
        tick(1);
        a2_phi1_i = 1'b1;
        tick(29);
        if (strobe_seen != 0) report_mismatch("strobe_count", 0, strobe_seen);
        if (phi0_o !== 1'b0) report_mismatch("phi0_o", 0, phi0_o);
        // Q3 glitch lands inside Phi0 of the cycle that follows
        run_bus_cycle(16'hc0a5, 8'h3c, 1'b0, 1'b1, 1'b1);
        end_test("glitch_reject", err_start);
    endtask

    task automatic test_late_data();
        int err_start;
        err_start = errors;
        run_bus_cycle(16'hc300, 8'h96, 1'b1, 1'b0, 1'b0);
        run_bus_cycle(A2_ADDR_W'($urandom), A2_DATA_W'($urandom), 1'b1, 1'b0, 1'b0);
        end_test("late_data", err_start);
    endtask

    task automatic test_data_priority();
        int                   err_start;
        logic [A2_DATA_W-1:0] exp_d;
        logic                 exp_dir;
        err_start = errors;
        for (int i = 0; i < 40; i++) begin
            {ssc_rd_i, ssp_rd_i, mb_rd_i} = 3'($urandom);
            ssc_data_i = A2_DATA_W'($urandom);
            ssp_data_i = A2_DATA_W'($urandom);
            mb_data_i  = A2_DATA_W'($urandom);
            if (ssc_rd_i) exp_d = ssc_data_i;
            else if (ssp_rd_i) exp_d = ssp_data_i;
            else if (mb_rd_i) exp_d = mb_data_i;
            else exp_d = last_data;
            exp_dir = (ssc_rd_i | ssp_rd_i | mb_rd_i) & BUS_DATA_OUT_ENABLE;
            tick(1);
            if (a2_d_o !== exp_d) report_mismatch("a2_d_o", exp_d, a2_d_o);
            if (a2_d_dir_o !== exp_dir) report_mismatch("a2_d_dir_o", exp_dir, a2_d_dir_o);
        end
        {ssc_rd_i, ssp_rd_i, mb_rd_i} = 3'b000;
        end_test("data_priority", err_start);
    endtask

    task automatic test_irq_combine();
        int   err_start;
        logic exp_irq;
        err_start = errors;
        for (int i = 0; i < 8; i++) begin
            {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = 3'(i);
            exp_irq = IRQ_OUT_ENABLE ? (i == 7) : 1'b1;
            tick(1);
            if (a2_irq_n_o !== exp_irq) report_mismatch("a2_irq_n_o", exp_irq, a2_irq_n_o);
        end
        {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = 3'b111;
        end_test("irq_combine", err_start);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        clk_logic_w  = 1'b0;
        rst_n_i      = 1'b0;
        a2_phi1_i    = 1'b1;
        a2_q3_i      = 1'b1;
        a2_a_i       = '0;
        a2_d_i       = '0;
        a2_rw_n_i    = 1'b1;
        {ssc_rd_i, ssp_rd_i, mb_rd_i} = 3'b000;
        {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = 3'b111;
        ssc_data_i   = '0;
        ssp_data_i   = '0;
        mb_data_i    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        strobe_seen  = 0;
        last_data    = '0;
        repeat (10) @(negedge clk_logic_w);
        rst_n_i = 1'b1;
        test_after_reset();
        test_cycle_capture();
        test_glitch_reject();
        test_late_data();
        test_data_priority();
        test_irq_combine();
        $display("tests run %0d, tests failing %0d, errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
a2_pkg.sv
edge_denoise.sv
bus_cycle_capture.sv
card_response_arbiter.sv
a2_bus_frontend.sv
tb_a2_bus_frontend.sv

/* Makefile */
TB_TOP  := tb_a2_bus_frontend
RTL_TOP := a2_bus_frontend

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TB_TOP) -o $(TB_TOP)

run: build
	@out="$$(./obj_dir/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

lint:
	verilator --lint-only --timing -f sources.f --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir
